/* hw/ex_pkg.sv */
// Shared types of the execute subsystem: operation enum, width typedefs, pipeline and commit structs
package ex_pkg;

  // Architectural register count, index 0 is hardwired to zero
  localparam int unsigned NUM_REGS = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Width typedefs
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] seq_t;

  // Operation encoding, 4 bits
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SRA   = 4'd7,
    OP_SLT   = 4'd8,
    OP_SLTU  = 4'd9,
    OP_MUL   = 4'd10,
    OP_MULHU = 4'd11
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline structs
  ////////////////////////////////////////////////////////////////////////////

  // Incoming command, 19 bits
  typedef struct packed {
    alu_op_e   op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
  } cmd_t;

  // Issue to execute
  typedef struct packed {
    logic      instr_valid;
    logic      alu_en;
    logic      mul_en;
    logic      rf_we;
    alu_op_e   op;
    word_t     operand_a;
    word_t     operand_b;
    reg_addr_t rd;
    seq_t      seq;
  } id_ex_pipe_t;

  // Execute to writeback
  typedef struct packed {
    logic      instr_valid;
    logic      rf_we;
    reg_addr_t rd;
    word_t     rf_wdata;
    seq_t      seq;
  } ex_wb_pipe_t;

  // Retiring result as seen on the commit port
  typedef struct packed {
    reg_addr_t rd;
    word_t     data;
    seq_t      seq;
  } commit_t;

  // Register write from writeback, also releases the scoreboard
  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } rf_wr_t;

endpackage

/* hw/ex_alu.sv */
// Single-cycle ALU: add, subtract, logic, shifts and set-less-than
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_op_e op_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o
);

  // Shift amount from the low bits of operand b
  logic [4:0]    shamt;
  ex_pkg::word_t sum;
  ex_pkg::word_t diff;
  logic          lt_signed;
  logic          lt_unsigned;

  assign shamt = operand_b_i[4:0];

  // Adder and subtractor kept apart for readability
  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Comparisons
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (op_i)
      ex_pkg::OP_ADD: begin
        result_o = sum;
      end
      ex_pkg::OP_SUB: begin
        result_o = diff;
      end
      ex_pkg::OP_AND: begin
        result_o = operand_a_i & operand_b_i;
      end
      ex_pkg::OP_OR: begin
        result_o = operand_a_i | operand_b_i;
      end
      ex_pkg::OP_XOR: begin
        result_o = operand_a_i ^ operand_b_i;
      end
      ex_pkg::OP_SLL: begin
        result_o = operand_a_i << shamt;
      end
      ex_pkg::OP_SRL: begin
        result_o = operand_a_i >> shamt;
      end
      ex_pkg::OP_SRA: begin
        result_o = ex_pkg::word_t'($signed(operand_a_i) >>> shamt);
      end
      // Set-less-than returns 0 or 1
      ex_pkg::OP_SLT: begin
        result_o = {31'b0, lt_signed};
      end
      ex_pkg::OP_SLTU: begin
        result_o = {31'b0, lt_unsigned};
      end
      // Multiply ops are served by the multiplier
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

/* hw/ex_mult.sv */
// Iterative shift-add multiplier with valid/ready handshakes, low or high unsigned product
`timescale 1ns/100ps

module ex_mult (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          high_i,
  input  ex_pkg::word_t op_a_i,
  input  ex_pkg::word_t op_b_i,
  input  logic          valid_i,
  output logic          ready_o,
  output logic          valid_o,
  input  logic          ready_i,
  output ex_pkg::word_t result_o
);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } mult_state_e;

  mult_state_e   state_q;
  logic [4:0]    cnt_q;
  // Multiplicand and selected half
  ex_pkg::word_t mcand_q;
  logic          high_q;
  // Upper half accumulates, lower half holds the remaining multiplier bits
  logic [63:0]   acc_q;
  logic [32:0]   partial;

  // Add multiplicand into the upper half when the current multiplier bit is set
  assign partial = {1'b0, acc_q[63:32]} + (acc_q[0] ? {1'b0, mcand_q} : 33'd0);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  // 1 cycle to start, 32 steps, then result held in DONE
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (valid_i) begin
            state_q <= CALC;
            cnt_q   <= 5'd31;
          end
        end
        CALC: begin
          cnt_q <= cnt_q - 5'd1;
          if (cnt_q == 5'd0) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          if (ready_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state_q == IDLE && valid_i) begin
      mcand_q <= op_a_i;
      high_q  <= high_i;
      acc_q   <= {32'b0, op_b_i};
    end else if (state_q == CALC) begin
      // Carry of the add shifts into bit 63
      acc_q <= {partial, acc_q[31:1]};
    end
  end

  // Ready once the result is taken, or when nothing is pending
  assign ready_o  = (state_q == IDLE && !valid_i) || (state_q == DONE && ready_i);
  assign valid_o  = state_q == DONE;
  assign result_o = high_q ? acc_q[63:32] : acc_q[31:0];

endmodule

/* hw/id_issue.sv */
// Issue stage: command intake, operand read, scoreboard interlock and ID/EX register
`timescale 1ns/100ps

module id_issue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cmd_valid_i,
  input  ex_pkg::cmd_t        cmd_i,
  output logic                cmd_ready_o,
  input  ex_pkg::word_t       rs1_data_i,
  input  ex_pkg::word_t       rs2_data_i,
  output ex_pkg::reg_addr_t   rs1_addr_o,
  output ex_pkg::reg_addr_t   rs2_addr_o,
  input  ex_pkg::rf_wr_t      rf_wr_i,
  input  logic                ex_ready_i,
  output ex_pkg::id_ex_pipe_t id_ex_pipe_o
);

  logic [ex_pkg::NUM_REGS-1:0] busy_q;
  logic [ex_pkg::NUM_REGS-1:0] busy_d;
  logic                        ready_en_q;
  logic                        accept;
  logic                        mul_op;
  logic                        dec_rf_we;
  ex_pkg::seq_t                seq_q;
  // ID/EX control
  logic                        valid_q;
  logic                        alu_en_q;
  logic                        mul_en_q;
  logic                        rf_we_q;
  // ID/EX payload
  ex_pkg::alu_op_e             op_q;
  ex_pkg::word_t               opa_q;
  ex_pkg::word_t               opb_q;
  ex_pkg::reg_addr_t           rd_q;
  ex_pkg::seq_t                tag_q;

  // Register read port follows the pending command
  assign rs1_addr_o = cmd_i.rs1;
  assign rs2_addr_o = cmd_i.rs2;

  // Decode
  assign mul_op    = cmd_i.op == ex_pkg::OP_MUL || cmd_i.op == ex_pkg::OP_MULHU;
  assign dec_rf_we = cmd_i.rd != '0;

  // Hold off on any busy source, and for one cycle out of reset
  assign cmd_ready_o = ready_en_q && ex_ready_i && !busy_q[cmd_i.rs1] && !busy_q[cmd_i.rs2];
  assign accept      = cmd_valid_i && cmd_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////////////////////

  // Release first so a new writer of the same rd wins
  always_comb begin
    busy_d = busy_q;
    if (rf_wr_i.we) begin
      busy_d[rf_wr_i.rd] = 1'b0;
    end
    if (accept && dec_rf_we) begin
      busy_d[cmd_i.rd] = 1'b1;
    end
    busy_d[0] = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= '0;
      ready_en_q <= 1'b0;
      seq_q      <= '0;
      valid_q    <= 1'b0;
      alu_en_q   <= 1'b0;
      mul_en_q   <= 1'b0;
      rf_we_q    <= 1'b0;
    end else begin
      busy_q     <= busy_d;
      ready_en_q <= 1'b1;
      if (accept) begin
        seq_q <= seq_q + 32'd1;
      end
      // Entry on acceptance, bubble otherwise
      if (ex_ready_i) begin
        valid_q  <= accept;
        alu_en_q <= !mul_op;
        mul_en_q <= mul_op;
        rf_we_q  <= dec_rf_we;
      end
    end
  end

  // Payload, tag is the count of commands accepted before this one
  always_ff @(posedge clk) begin
    if (ex_ready_i && accept) begin
      op_q  <= cmd_i.op;
      opa_q <= rs1_data_i;
      opb_q <= rs2_data_i;
      rd_q  <= cmd_i.rd;
      tag_q <= seq_q;
    end
  end

  assign id_ex_pipe_o = '{valid_q, alu_en_q, mul_en_q, rf_we_q, op_q, opa_q, opb_q, rd_q, tag_q};

endmodule

/* hw/ex_stage.sv */
// Execute stage: ALU and multiplier, halt gating, result mux, stage handshake and EX/WB register
`timescale 1ns/100ps

module ex_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::id_ex_pipe_t id_ex_pipe_i,
  input  logic                halt_ex_i,
  output logic                ex_ready_o,
  input  logic                wb_ready_i,
  output ex_pkg::ex_wb_pipe_t ex_wb_pipe_o
);

  ex_pkg::word_t     alu_result;
  ex_pkg::word_t     mul_result;
  ex_pkg::word_t     rf_wdata;
  logic              instr_valid;
  logic              mul_en_gated;
  logic              mul_high;
  logic              alu_ready;
  logic              mul_ready;
  logic              mul_valid;
  logic              mul_take;
  logic              ex_valid;
  // EX/WB control
  logic              wb_valid_q;
  logic              wb_rf_we_q;
  // EX/WB payload
  ex_pkg::reg_addr_t wb_rd_q;
  ex_pkg::word_t     wb_data_q;
  ex_pkg::seq_t      wb_seq_q;

  // Halt makes the entry look invalid
  assign instr_valid  = id_ex_pipe_i.instr_valid && !halt_ex_i;
  assign mul_en_gated = id_ex_pipe_i.mul_en && instr_valid;
  assign mul_high     = id_ex_pipe_i.op == ex_pkg::OP_MULHU;

  ////////////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .op_i        (id_ex_pipe_i.op),
    .operand_a_i (id_ex_pipe_i.operand_a),
    .operand_b_i (id_ex_pipe_i.operand_b),
    .result_o    (alu_result)
  );

  // Finished product is only released when EX/WB can actually take it
  assign mul_take = wb_ready_i && !halt_ex_i;

  ex_mult u_mult (
    .clk      (clk),
    .rst_n    (rst_n),
    .high_i   (mul_high),
    .op_a_i   (id_ex_pipe_i.operand_a),
    .op_b_i   (id_ex_pipe_i.operand_b),
    .valid_i  (mul_en_gated),
    .ready_o  (mul_ready),
    .valid_o  (mul_valid),
    .ready_i  (mul_take),
    .result_o (mul_result)
  );

  // ALU takes a new entry whenever WB does
  assign alu_ready = wb_ready_i;

  // Write data select
  assign rf_wdata = id_ex_pipe_i.mul_en ? mul_result : alu_result;

  // Stage handshake, ALU results are valid in the same cycle
  assign ex_ready_o = alu_ready && mul_ready && !halt_ex_i;
  assign ex_valid   = (id_ex_pipe_i.alu_en ||
                       (id_ex_pipe_i.mul_en && mul_valid)) && instr_valid;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  // Load on a valid result, bubble when WB is free, hold otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
      wb_rf_we_q <= 1'b0;
    end else if (ex_valid && wb_ready_i) begin
      wb_valid_q <= 1'b1;
      wb_rf_we_q <= id_ex_pipe_i.rf_we;
    end else if (wb_ready_i) begin
      wb_valid_q <= 1'b0;
      wb_rf_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid && wb_ready_i) begin
      wb_rd_q   <= id_ex_pipe_i.rd;
      wb_data_q <= rf_wdata;
      wb_seq_q  <= id_ex_pipe_i.seq;
    end
  end

  assign ex_wb_pipe_o = '{wb_valid_q, wb_rf_we_q, wb_rd_q, wb_data_q, wb_seq_q};

endmodule

/* hw/wb_stage.sv */
// Writeback stage: register file with two read ports, commit port and register write
`timescale 1ns/100ps

module wb_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::ex_wb_pipe_t ex_wb_pipe_i,
  input  logic                commit_ready_i,
  output logic                wb_ready_o,
  output logic                commit_valid_o,
  output ex_pkg::commit_t     commit_o,
  output ex_pkg::rf_wr_t      rf_wr_o,
  input  ex_pkg::reg_addr_t   rs1_addr_i,
  input  ex_pkg::reg_addr_t   rs2_addr_i,
  output ex_pkg::word_t       rs1_data_o,
  output ex_pkg::word_t       rs2_data_o
);

  // Writable registers 1 to 31
  ex_pkg::word_t               rf_q [1:ex_pkg::NUM_REGS-1];
  // Written-since-reset flags, unwritten registers read as zero
  logic [ex_pkg::NUM_REGS-1:1] written_q;
  logic                        retire;

  ////////////////////////////////////////////////////////////////////////////
  // Commit
  ////////////////////////////////////////////////////////////////////////////

  // WB accepts whenever the commit port does
  assign wb_ready_o     = commit_ready_i;
  assign commit_valid_o = ex_wb_pipe_i.instr_valid;
  assign commit_o       = '{ex_wb_pipe_i.rd, ex_wb_pipe_i.rf_wdata, ex_wb_pipe_i.seq};
  assign retire         = ex_wb_pipe_i.instr_valid && commit_ready_i;

  // Write and scoreboard release on the retiring edge
  assign rf_wr_o = '{retire && ex_wb_pipe_i.rf_we, ex_wb_pipe_i.rd, ex_wb_pipe_i.rf_wdata};

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      written_q <= '0;
    end else if (rf_wr_o.we && rf_wr_o.rd != '0) begin
      written_q[rf_wr_o.rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rf_wr_o.we && rf_wr_o.rd != '0) begin
      rf_q[rf_wr_o.rd] <= rf_wr_o.data;
    end
  end

  // Index 0 always reads zero
  assign rs1_data_o = (rs1_addr_i != '0 && written_q[rs1_addr_i]) ? rf_q[rs1_addr_i] : '0;
  assign rs2_data_o = (rs2_addr_i != '0 && written_q[rs2_addr_i]) ? rf_q[rs2_addr_i] : '0;

endmodule

/* hw/ex_top.sv */
// Top level of the execute subsystem: issue, execute and writeback stages
`timescale 1ns/100ps

module ex_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            cmd_valid_i,
  input  ex_pkg::cmd_t    cmd_i,
  output logic            cmd_ready_o,
  input  logic            halt_ex_i,
  input  logic            commit_ready_i,
  output logic            commit_valid_o,
  output ex_pkg::commit_t commit_o
);

  // Register read port between writeback and issue
  ex_pkg::reg_addr_t   rs1_addr;
  ex_pkg::reg_addr_t   rs2_addr;
  ex_pkg::word_t       rs1_data;
  ex_pkg::word_t       rs2_data;
  ex_pkg::rf_wr_t      rf_wr;
  // Stage pipes and readies
  ex_pkg::id_ex_pipe_t id_ex_pipe;
  ex_pkg::ex_wb_pipe_t ex_wb_pipe;
  logic                ex_ready;
  logic                wb_ready;

  id_issue u_issue (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .cmd_ready_o  (cmd_ready_o),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rf_wr_i      (rf_wr),
    .ex_ready_i   (ex_ready),
    .id_ex_pipe_o (id_ex_pipe)
  );

  // Halt reaches the execute stage only
  ex_stage u_ex (
    .clk          (clk),
    .rst_n        (rst_n),
    .id_ex_pipe_i (id_ex_pipe),
    .halt_ex_i    (halt_ex_i),
    .ex_ready_o   (ex_ready),
    .wb_ready_i   (wb_ready),
    .ex_wb_pipe_o (ex_wb_pipe)
  );

  wb_stage u_wb (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_wb_pipe_i   (ex_wb_pipe),
    .commit_ready_i (commit_ready_i),
    .wb_ready_o     (wb_ready),
    .commit_valid_o (commit_valid_o),
    .commit_o       (commit_o),
    .rf_wr_o        (rf_wr),
    .rs1_addr_i     (rs1_addr),
    .rs2_addr_i     (rs2_addr),
    .rs1_data_o     (rs1_data),
    .rs2_data_o     (rs2_data)
  );

endmodule

/* test/ex_asserts.sv */
// Protocol assertions on the execute subsystem top level and their bind into ex_top
`timescale 1ns/100ps

module ex_asserts (
  input logic            clk,
  input logic            rst_n,
  input logic            cmd_valid_i,
  input ex_pkg::cmd_t    cmd_i,
  input logic            cmd_ready_i,
  input logic            halt_ex_i,
  input logic            commit_ready_i,
  input logic            commit_valid_i,
  input ex_pkg::commit_t commit_i
);

  // Expected tag of the next retirement
  ex_pkg::seq_t next_seq_q;
  // Sticky flags, one per property
  bit           hold_fail;
  bit           stable_fail;
  bit           seq_fail;
  bit           halt_fail;
  bit           reset_fail;
  logic         any_fail;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_seq_q <= '0;
    end else if (commit_valid_i && commit_ready_i) begin
      next_seq_q <= next_seq_q + 32'd1;
    end
  end

  assign any_fail = hold_fail | stable_fail | seq_fail | halt_fail | reset_fail;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake rules
  ////////////////////////////////////////////////////////////////////////////

  // Offered command stays put until taken
  cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_i))
    else begin
      hold_fail = 1'b1;
      $error("command changed or withdrawn before acceptance");
    end

  // Commit port holds under back-pressure
  commit_stable: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid_i && !commit_ready_i |=> commit_valid_i && $stable(commit_i))
    else begin
      stable_fail = 1'b1;
      $error("commit port changed while stalled");
    end

  // One retirement per tag, none skipped
  commit_seq: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid_i && commit_ready_i |-> commit_i.seq == next_seq_q)
    else begin
      seq_fail = 1'b1;
      $error("commit tag out of order");
    end

  // Halted EX passes only bubbles into EX/WB
  halt_block: assert property (@(posedge clk) disable iff (!rst_n)
    halt_ex_i && commit_ready_i |=> !commit_valid_i)
    else begin
      halt_fail = 1'b1;
      $error("result reached the commit port while halted");
    end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !cmd_ready_i && !commit_valid_i)
    else begin
      reset_fail = 1'b1;
      $error("ready or commit valid high during reset");
    end

endmodule

bind ex_top ex_asserts u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .cmd_valid_i    (cmd_valid_i),
  .cmd_i          (cmd_i),
  .cmd_ready_i    (cmd_ready_o),
  .halt_ex_i      (halt_ex_i),
  .commit_ready_i (commit_ready_i),
  .commit_valid_i (commit_valid_o),
  .commit_i       (commit_o)
);

/* test/ex_tb.sv */
// Testbench of the execute subsystem: clock, reset, random commands, back-pressure, model, checks
`timescale 1ns/100ps

module ex_tb;

  localparam int unsigned NUM_COMMITS = 400;
  localparam int unsigned TIMEOUT     = 200;
  // Registers 1 to 7 get a random start value
  localparam int unsigned NUM_SEEDS   = 7;

  logic            clk;
  logic            rst_n;
  logic            cmd_valid;
  ex_pkg::cmd_t    cmd;
  logic            cmd_ready;
  logic            halt_ex;
  logic            commit_ready;
  logic            commit_valid;
  ex_pkg::commit_t commit;

  // Reference model state
  ex_pkg::word_t   model_rf [32];
  ex_pkg::commit_t exp_q [$];
  integer          seed;
  int unsigned     accepted;
  int unsigned     retired;
  int unsigned     idle_cycles;
  int unsigned     halt_left;
  int unsigned     seeds_done;
  // Seed commands take operand a from a forced register read
  bit              is_seed;
  bit              forcing;
  ex_pkg::word_t   seed_val;
  bit              cmd_fire;
  bit              commit_fire;

  always #2 clk = ~clk;

  ex_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_i          (cmd),
    .cmd_ready_o    (cmd_ready),
    .halt_ex_i      (halt_ex),
    .commit_ready_i (commit_ready),
    .commit_valid_o (commit_valid),
    .commit_o       (commit)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, ex_pkg::word_t exp_val, ex_pkg::word_t act_val);
    assert (exp_val == act_val)
      else abort_run($sformatf("mismatch %s expected %h actual %h", name, exp_val, act_val));
  endtask

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Expected result from the operation rules
  function automatic ex_pkg::word_t model_result(ex_pkg::alu_op_e op, ex_pkg::word_t a,
                                                 ex_pkg::word_t b);
    logic [63:0] prod;
    logic [63:0] sra;
    logic [4:0]  sh;
    sh   = b[4:0];
    prod = {32'b0, a} * {32'b0, b};
    // Arithmetic shift as a logical shift of the sign-extended word
    sra  = {{32{a[31]}}, a} >> sh;
    case (op)
      ex_pkg::OP_ADD:   return a + b;
      ex_pkg::OP_SUB:   return a - b;
      ex_pkg::OP_AND:   return a & b;
      ex_pkg::OP_OR:    return a | b;
      ex_pkg::OP_XOR:   return a ^ b;
      ex_pkg::OP_SLL:   return a << sh;
      ex_pkg::OP_SRL:   return a >> sh;
      ex_pkg::OP_SRA:   return sra[31:0];
      ex_pkg::OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ex_pkg::OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      ex_pkg::OP_MUL:   return prod[31:0];
      ex_pkg::OP_MULHU: return prod[63:32];
      default:          return '0;
    endcase
  endfunction

  // Destination of a command that has not committed yet
  function automatic bit rd_in_flight(ex_pkg::reg_addr_t rd);
    foreach (exp_q[i]) begin
      if (rd != '0 && exp_q[i].rd == rd) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Apply an accepted command to the model in acceptance order
  task automatic accept_command();
    ex_pkg::word_t   a;
    ex_pkg::word_t   b;
    ex_pkg::commit_t e;
    a      = is_seed ? seed_val : model_rf[cmd.rs1];
    b      = model_rf[cmd.rs2];
    e.rd   = cmd.rd;
    e.data = model_result(cmd.op, a, b);
    e.seq  = ex_pkg::seq_t'(accepted);
    exp_q.push_back(e);
    // Register 0 keeps reading zero
    if (cmd.rd != '0) begin
      model_rf[cmd.rd] = e.data;
    end
    accepted++;
    if (is_seed) begin
      seeds_done++;
    end
  endtask

  task automatic check_commit();
    ex_pkg::commit_t e;
    if (exp_q.size() == 0) begin
      abort_run("commit seen while no accepted command was outstanding");
    end else begin
      e = exp_q.pop_front();
      check_value("commit_seq", e.seq, commit.seq);
      check_value("commit_rd", ex_pkg::word_t'(e.rd), ex_pkg::word_t'(commit.rd));
      check_value("commit_data", e.data, commit.data);
    end
  endtask

  // New command that stays as is while offered and not taken
  task automatic drive_inputs();
    ex_pkg::cmd_t c;
    commit_ready = rand_below(4) != 0;
    if (halt_left != 0) begin
      halt_left--;
      halt_ex = 1'b1;
    end else if (rand_below(48) == 0) begin
      halt_left = rand_below(10);
      halt_ex   = 1'b1;
    end else begin
      halt_ex = 1'b0;
    end
    if (!cmd_valid || cmd_fire) begin
      if (seeds_done < NUM_SEEDS) begin
        // OR of a forced value with r0 loads the next register
        seed_val = ex_pkg::word_t'($random(seed));
        is_seed  = 1'b1;
        forcing  = 1'b1;
        force DUT.rs1_data = seed_val;
        cmd       = '{ex_pkg::OP_OR, 5'd0, 5'd0, ex_pkg::reg_addr_t'(seeds_done + 1)};
        cmd_valid = 1'b1;
      end else begin
        if (forcing) begin
          release DUT.rs1_data;
          forcing = 1'b0;
        end
        is_seed = 1'b0;
        // Small register set so that hazards come often
        c.op  = ex_pkg::alu_op_e'(4'(rand_below(12)));
        c.rs1 = ex_pkg::reg_addr_t'(rand_below(8));
        c.rs2 = ex_pkg::reg_addr_t'(rand_below(8));
        c.rd  = ex_pkg::reg_addr_t'(rand_below(8));
        // No second writer while the first is in flight
        if (rd_in_flight(c.rd)) begin
          c.rd = '0;
        end
        cmd       = c;
        cmd_valid = rand_below(4) != 0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 65665;
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    halt_ex      = 1'b0;
    // Commit side open so only the issue stage can hold cmd_ready low
    commit_ready = 1'b1;
    accepted     = 0;
    retired      = 0;
    idle_cycles  = 0;
    halt_left    = 0;
    seeds_done   = 0;
    is_seed      = 1'b0;
    forcing      = 1'b0;
    cmd_fire     = 1'b0;
    commit_fire  = 1'b0;
    foreach (model_rf[i]) begin
      model_rf[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Both still low in the first cycle out of reset
    assert (!cmd_ready && !commit_valid)
      else abort_run("cmd_ready or commit_valid high in the first cycle after reset");
    drive_inputs();
    while (retired < NUM_COMMITS) begin
      // Handshakes of the coming edge sampled at the falling edge
      @(negedge clk);
      cmd_fire    = cmd_valid && cmd_ready;
      commit_fire = commit_valid && commit_ready;
      if (commit_fire) begin
        check_commit();
      end
      @(posedge clk);
      #1;
      if (DUT.u_asserts.any_fail) begin
        abort_run("protocol assertion failed on the top level");
      end else if (idle_cycles > TIMEOUT) begin
        abort_run("no commit within the timeout");
      end else begin
        if (cmd_fire) begin
          accept_command();
        end
        if (commit_fire) begin
          retired++;
          idle_cycles = 0;
        end else begin
          idle_cycles++;
        end
        drive_inputs();
      end
    end
    if (DUT.u_asserts.any_fail) begin
      abort_run("protocol assertion failed on the top level");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

/* sources.f */
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/id_issue.sv
hw/ex_stage.sv
hw/wb_stage.sv
hw/ex_top.sv
test/ex_asserts.sv
test/ex_tb.sv

/* Makefile */
# Verilator build and run of the execute subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := ex_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Pass only if the log holds the pass message
run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
